//--- Bender.yml
package:
  name: cache_bank

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/cache_types_pkg.sv
      - verilog/mem_req_pkg.sv
      - verilog/lookup_decode.sv
      - verilog/lru_tracker.sv
      - verilog/refill_execute.sv
      - verilog/response_result.sv
      - verilog/cache_bank_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - dv/tb_clock.sv
      - dv/cache_bank_tb.sv

//--- build.f
+incdir+verilog
verilog/cache_types_pkg.sv
verilog/mem_req_pkg.sv
verilog/lookup_decode.sv
verilog/lru_tracker.sv
verilog/refill_execute.sv
verilog/response_result.sv
verilog/cache_bank_top.sv
dv/tb_clock.sv
dv/cache_bank_tb.sv

//--- dv/cache_bank_tb.sv
`include "cache_macros.svh"
`timescale 1ns/1ps

module cache_bank_tb;

  localparam int NUM_REQS       = 400;
  localparam int TIMEOUT_CYCLES = NUM_REQS * 40;

  logic                 CLK, reset;
  logic                 req_valid, req_rw;
  logic [`ADDR_LEN-1:0] req_addr;
  logic [`WORD_LEN-1:0] req_store_value;
  logic                 resp_valid, busy;
  logic [`WORD_LEN-1:0] resp_load_value;
  logic                 mem_read, mem_write, mem_rvalid;
  logic [`ADDR_LEN-1:0] mem_addr;
  logic [`WORD_LEN-1:0] mem_wdata, mem_rdata;

  integer               seed = 32'h129d32fa;
  int                   cycle_count = 0;
  int                   pending = 0;         // Accepted requests without response
  logic                 reset_q = 1'b0;
  logic                 cur_rw = 1'b0;
  logic [`WORD_LEN-1:0] cur_exp = '0;
  logic                 expect_hit = 1'b0;
  logic                 expect_miss = 1'b0;
  logic [`WORD_LEN-1:0] shadow [0:(1<<`ADDR_LEN)-1];
  logic [`WORD_LEN-1:0] memory [0:(1<<`ADDR_LEN)-1];
  logic                 rd_pending = 1'b0;
  logic [1:0]           rd_delay = '0;
  logic [`ADDR_LEN-1:0] rd_addr = '0;

  tb_clock u_clock (.CLK, .reset);

  cache_bank_top DUT (
    .CLK, .reset, .req_valid, .req_rw, .req_addr, .req_store_value, .resp_valid,
    .resp_load_value, .busy, .mem_read, .mem_write, .mem_addr, .mem_wdata, .mem_rvalid,
    .mem_rdata
  );

  task automatic stop_with_error(input string line);
    $display("%s", line);
    $display("Test FAILED");
    $fatal(1);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Memory model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    for (int a = 0; a < (1 << `ADDR_LEN); a++) begin
      memory[a] = a * 3;
      shadow[a] = a * 3;
    end
  end

  always @(posedge CLK) begin
    mem_rvalid <= 1'b0;
    if (rd_pending) begin
      if (rd_delay == 0) begin
        mem_rvalid <= 1'b1;
        mem_rdata  <= memory[rd_addr];
        rd_pending <= 1'b0;
      end else begin
        rd_delay <= rd_delay - 1'b1;
      end
    end
    if (mem_read) begin
      rd_pending <= 1'b1;
      rd_delay   <= 2'({$random(seed)} % 3);   // Answer 1 to 3 cycles later
      rd_addr    <= mem_addr;
    end
    if (mem_write) begin
      memory[mem_addr] <= mem_wdata;
    end
  end

  always @(posedge CLK) begin
    reset_q     <= reset;
    cycle_count <= cycle_count + 1;
    pending     <= pending + ((req_valid && !busy) ? 1 : 0) - (resp_valid ? 1 : 0);
    if (cycle_count >= TIMEOUT_CYCLES) begin
      stop_with_error($sformatf("timeout: run did not end within %0d cycles", TIMEOUT_CYCLES));
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assert property (@(posedge CLK) reset_q |-> !resp_valid && !busy && !mem_read && !mem_write)
    else stop_with_error("outputs not low during or just after reset");

  assert property (@(posedge CLK) disable iff (reset)
                   (resp_valid && !cur_rw) |-> (resp_load_value == cur_exp))
    else stop_with_error($sformatf("mismatch at %0t: load got %h, expected %h",
                                   $time, resp_load_value, cur_exp));

  assert property (@(posedge CLK) disable iff (reset)
                   (req_valid && !busy && expect_hit) |=> resp_valid)
    else stop_with_error("hit did not respond one cycle after acceptance");

  assert property (@(posedge CLK) disable iff (reset) expect_hit |-> !mem_read)
    else stop_with_error("memory read issued for a block that should be resident");

  assert property (@(posedge CLK) disable iff (reset)
                   (req_valid && !busy && expect_miss) |=> busy)
    else stop_with_error("request expected to miss was served as a hit");

  assert property (@(posedge CLK) disable iff (reset) resp_valid |-> (pending == 1))
    else stop_with_error("response without exactly one outstanding request");

  assert property (@(posedge CLK) disable iff (reset) $fell(busy) |-> resp_valid)
    else stop_with_error("busy fell without a response");

  assert property (@(posedge CLK) disable iff (reset) mem_write |-> (mem_wdata == shadow[mem_addr]))
    else stop_with_error($sformatf("mismatch at %0t: write-back to %h carries %h, expected %h",
                                   $time, mem_addr, mem_wdata, shadow[mem_addr]));

  assert property (@(posedge CLK) disable iff (reset)
                   $rose(mem_write) |-> (mem_addr[`BLOCK_OFF_BIT_LEN-1:0] == 0) ##0
                   mem_write [*`BLOCK_SIZE] ##1 !mem_write)
    else stop_with_error("eject burst not BLOCK_SIZE consecutive writes from word 0");

  assert property (@(posedge CLK) disable iff (reset)
                   (mem_write && $past(mem_write)) |-> (mem_addr == $past(mem_addr) + 1'b1))
    else stop_with_error($sformatf("mismatch at %0t: eject address %h not consecutive",
                                   $time, mem_addr));

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Sends one request and returns after its response
  task automatic send_request(input logic rw, input logic [`ADDR_LEN-1:0] addr,
                              input logic [`WORD_LEN-1:0] data, input logic want_hit,
                              input logic want_miss);
    @(posedge CLK);
    req_valid       <= 1'b1;
    req_rw          <= rw;
    req_addr        <= addr;
    req_store_value <= data;
    cur_rw          <= rw;
    cur_exp         <= shadow[addr];
    expect_hit      <= want_hit;
    expect_miss     <= want_miss;
    @(posedge CLK);
    req_valid <= 1'b0;
    if (rw) begin
      shadow[addr] = data;                     // Store accepted at this edge
    end
    do begin
      @(negedge CLK);
    end while (!resp_valid);
  endtask

  function automatic logic [`ADDR_LEN-1:0] make_addr(input int tag, input int set, input int off);
    return {`TAG_LEN'(tag), `BLOCK_INDEX_BIT_LEN'(set), `BLOCK_OFF_BIT_LEN'(off)};
  endfunction

  initial begin
    logic [`ADDR_LEN-1:0] addr;
    logic [31:0]          r;
    req_valid       = 1'b0;
    req_rw          = 1'b0;
    req_addr        = '0;
    req_store_value = '0;
    mem_rvalid      = 1'b0;
    mem_rdata       = '0;
    do begin
      @(negedge CLK);
    end while (reset);

    send_request(1'b0, make_addr(0, 0, 0), '0, 1'b0, 1'b1);
    send_request(1'b0, make_addr(0, 0, 1), '0, 1'b1, 1'b0);
    send_request(1'b1, make_addr(0, 0, 2), 32'hcafe_0002, 1'b1, 1'b0);
    send_request(1'b0, make_addr(0, 0, 2), '0, 1'b1, 1'b0);

    // Five tags into set 2 so that the fifth evicts the first
    for (int t = 0; t < `NUM_WAYS + 1; t++) begin
      send_request(1'b0, make_addr(16 + t, 2, 0), '0, 1'b0, 1'b1);
      send_request(1'b1, make_addr(16 + t, 2, 1), 32'h5100_0000 + t, 1'b1, 1'b0);
    end
    send_request(1'b0, make_addr(16, 2, 1), '0, 1'b0, 1'b1);
    for (int t = 2; t < `NUM_WAYS + 1; t++) begin
      send_request(1'b0, make_addr(16 + t, 2, 1), '0, 1'b1, 1'b0);
    end
    send_request(1'b0, make_addr(16, 2, 3), '0, 1'b1, 1'b0);

    // Random pairs over 32 addresses where the second touch of a pair always hits
    for (int i = 0; i < 190; i++) begin
      r    = $random(seed);
      addr = make_addr(r[4:2], 1, r[1:0]);
      send_request(r[8], addr, $random(seed), 1'b0, 1'b0);
      r    = $random(seed);
      send_request(r[8], {addr[`ADDR_LEN-1:`BLOCK_OFF_BIT_LEN], r[1:0]}, $random(seed),
                   1'b1, 1'b0);
    end

    @(negedge CLK);
    $display("Test OK");
    $finish;
  end

endmodule

//--- dv/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic CLK,
  output logic reset
);

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;      // 8 ns period
  end

  initial begin
    reset = 1'b1;
    repeat (5) @(posedge CLK);
    reset <= 1'b0;
  end

endmodule

//--- verilog/cache_bank_top.sv
`include "cache_macros.svh"
`timescale 1ns/1ps

module cache_bank_top import cache_types_pkg::*, mem_req_pkg::*; (
  input  logic                 CLK,
  input  logic                 reset,
  input  logic                 req_valid,
  input  logic                 req_rw,
  input  logic [`ADDR_LEN-1:0] req_addr,
  input  logic [`WORD_LEN-1:0] req_store_value,
  output logic                 resp_valid,
  output logic [`WORD_LEN-1:0] resp_load_value,
  output logic                 busy,
  output logic                 mem_read,
  output logic                 mem_write,
  output logic [`ADDR_LEN-1:0] mem_addr,
  output logic [`WORD_LEN-1:0] mem_wdata,
  input  logic                 mem_rvalid,
  input  logic [`WORD_LEN-1:0] mem_rdata
);

  cache_set [`NUM_SETS_PER_BANK-1:0] bank;
  lru_frame [`NUM_SETS_PER_BANK-1:0] lru;
  cache_addr_u                       replay_addr;
  cache_addr_u                       decode_addr;
  logic                              hit;
  logic [`WAYS_LEN-1:0]              hit_way_index;
  logic [`BLOCK_INDEX_BIT_LEN-1:0]   set_index;
  logic [`BLOCK_OFF_BIT_LEN-1:0]     block_offset;
  logic                              touch;
  logic [`BLOCK_INDEX_BIT_LEN-1:0]   touch_set;
  logic [`WAYS_LEN-1:0]              touch_way;
  logic [`BLOCK_INDEX_BIT_LEN-1:0]   victim_set;
  logic [`WAYS_LEN-1:0]              victim_way;
  logic                              finish;
  logic                              result_valid;
  logic                              result_rw;
  logic [`WORD_LEN-1:0]              result_word;

  assign decode_addr = busy ? replay_addr : req_addr;  // Miss address during refill

  lookup_decode u_decode (
    .CLK, .req_addr(decode_addr), .bank, .hit, .hit_way_index, .set_index,
    .tag(), .block_offset
  );

  lru_tracker u_lru (
    .CLK, .reset, .touch, .touch_set, .touch_way, .victim_set, .victim_way, .finish, .lru
  );

  refill_execute u_execute (
    .CLK, .reset, .req_valid, .req_rw, .req_store_value, .req_addr, .hit, .hit_way_index,
    .set_index, .block_offset, .lru, .bank, .busy, .replay_addr, .touch, .touch_set,
    .touch_way, .victim_set, .victim_way, .finish, .result_valid, .result_rw,
    .result_word, .mem_read, .mem_write, .mem_addr, .mem_wdata, .mem_rvalid, .mem_rdata
  );

  response_result u_result (
    .CLK, .reset, .result_valid, .result_rw, .result_word, .resp_valid, .resp_load_value
  );

endmodule

//--- verilog/cache_macros.svh
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bank geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define NUM_SETS_PER_BANK 4
`define NUM_WAYS 4
`define WAYS_LEN 2
`define BLOCK_SIZE 4

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address and data widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define BLOCK_OFF_BIT_LEN 2                   // Word within a block
`define BLOCK_INDEX_BIT_LEN 2                 // Set within the bank
`define ADDR_LEN 12                           // Word address
`define TAG_LEN (`ADDR_LEN - `BLOCK_INDEX_BIT_LEN - `BLOCK_OFF_BIT_LEN)
`define WORD_LEN 32

// Way age counter, wide enough to rank all ways
`define AGE_LEN 2

`endif

//--- verilog/cache_types_pkg.sv
`include "cache_macros.svh"

package cache_types_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Storage
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic                                   valid;
    logic [`TAG_LEN-1:0]                    tag;
    logic [`BLOCK_SIZE-1:0][`WORD_LEN-1:0]  block;  // Word 0 in the low bits
  } cache_frame;

  typedef cache_frame [`NUM_WAYS-1:0] cache_set;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Replacement
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic [`NUM_WAYS-1:0][`AGE_LEN-1:0] age;    // 0 is most recent
    logic [`WAYS_LEN-1:0]               lru_way;
  } lru_frame;

  // Miss handling sequence
  typedef enum logic [2:0] {
    IDLE         = 3'd0,
    VICTIM_EJECT = 3'd1,
    BLOCK_PULL   = 3'd2,
    FINISH       = 3'd3,
    REPLAY       = 3'd4
  } cache_state_e;

endpackage

//--- verilog/lookup_decode.sv
`include "cache_macros.svh"
`timescale 1ns/1ps

module lookup_decode import cache_types_pkg::*, mem_req_pkg::*; (
  input  logic                                CLK,
  input  cache_addr_u                         req_addr,
  input  cache_set [`NUM_SETS_PER_BANK-1:0]   bank,
  output logic                                hit,
  output logic [`WAYS_LEN-1:0]                hit_way_index,
  output logic [`BLOCK_INDEX_BIT_LEN-1:0]     set_index,
  output logic [`TAG_LEN-1:0]                 tag,
  output logic [`BLOCK_OFF_BIT_LEN-1:0]       block_offset
);

  logic [`NUM_WAYS-1:0] hit_vec;
  logic                 dup_tag;

  assign tag          = req_addr.fields.tag;
  assign set_index    = req_addr.fields.set_index;
  assign block_offset = req_addr.fields.block_offset;

  always_comb begin
    for (int w = 0; w < `NUM_WAYS; w++) begin
      hit_vec[w] = bank[set_index][w].valid && (bank[set_index][w].tag == tag);
    end
  end

  assign hit = |hit_vec;

  // One-hot to index
  always_comb begin
    hit_way_index = '0;
    for (int w = 0; w < `NUM_WAYS; w++) begin
      if (hit_vec[w]) begin
        hit_way_index = `WAYS_LEN'(w);
      end
    end
  end

  // Same valid tag in two ways of the looked-up set
  always_comb begin
    dup_tag = 1'b0;
    for (int i = 0; i < `NUM_WAYS; i++) begin
      for (int j = i + 1; j < `NUM_WAYS; j++) begin
        if (bank[set_index][i].valid && bank[set_index][j].valid &&
            (bank[set_index][i].tag == bank[set_index][j].tag)) begin
          dup_tag = 1'b1;
        end
      end
    end
  end

  // A refill never places a block that is already resident
  assert property (@(posedge CLK) dup_tag !== 1'b1)
    else $error("ASSERTIONERROR: duplicate valid tag in set %0d", set_index);

endmodule

//--- verilog/lru_tracker.sv
`include "cache_macros.svh"
`timescale 1ns/1ps

module lru_tracker import cache_types_pkg::*; (
  input  logic                                CLK,
  input  logic                                reset,
  input  logic                                touch,
  input  logic [`BLOCK_INDEX_BIT_LEN-1:0]     touch_set,
  input  logic [`WAYS_LEN-1:0]                touch_way,
  input  logic [`BLOCK_INDEX_BIT_LEN-1:0]     victim_set,
  input  logic [`WAYS_LEN-1:0]                victim_way,
  input  logic                                finish,
  output lru_frame [`NUM_SETS_PER_BANK-1:0]   lru
);

  localparam logic [`AGE_LEN-1:0] AGE_MAX = '1;

  logic [`NUM_SETS_PER_BANK-1:0][`NUM_WAYS-1:0][`AGE_LEN-1:0] age_q;
  logic [`NUM_SETS_PER_BANK-1:0][`WAYS_LEN-1:0]                oldest;

  // Touched way goes to 0, ways not older than it move up by one
  always_ff @(posedge CLK) begin
    if (reset) begin
      age_q <= '0;
    end else if (touch) begin
      for (int w = 0; w < `NUM_WAYS; w++) begin
        if (`WAYS_LEN'(w) == touch_way) begin
          age_q[touch_set][w] <= '0;
        end else if ((age_q[touch_set][w] <= age_q[touch_set][touch_way]) &&
                     (age_q[touch_set][w] != AGE_MAX)) begin
          age_q[touch_set][w] <= age_q[touch_set][w] + 1'b1;
        end
      end
    end
  end

  // Lowest index wins a tie, so empty ways fill in order
  always_comb begin
    for (int s = 0; s < `NUM_SETS_PER_BANK; s++) begin
      oldest[s] = '0;
      for (int w = 1; w < `NUM_WAYS; w++) begin
        if (age_q[s][w] > age_q[s][oldest[s]]) begin
          oldest[s] = `WAYS_LEN'(w);
        end
      end
      lru[s].age     = age_q[s];
      lru[s].lru_way = oldest[s];
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  for (genvar s = 0; s < `NUM_SETS_PER_BANK; s++) begin : g_set
    for (genvar w = 0; w < `NUM_WAYS; w++) begin : g_way
      assert property (@(posedge CLK) disable iff (reset)
                       lru[s].age[lru[s].lru_way] >= lru[s].age[w])
        else $error("ASSERTIONERROR: set %0d LRU way %0d younger than way %0d",
                    s, lru[s].lru_way, w);
    end
  end

  // Refilled victim becomes the most recent way
  assert property (@(posedge CLK) disable iff (reset)
                   finish |=> (lru[$past(victim_set)].age[$past(victim_way)] == '0))
    else $error("ASSERTIONERROR: victim age not cleared after FINISH");

endmodule

//--- verilog/mem_req_pkg.sv
`include "cache_macros.svh"

package mem_req_pkg;

  // Address as seen by the tag lookup
  typedef struct packed {
    logic [`TAG_LEN-1:0]             tag;
    logic [`BLOCK_INDEX_BIT_LEN-1:0] set_index;
    logic [`BLOCK_OFF_BIT_LEN-1:0]   block_offset;
  } addr_fields_t;

  // Address as seen by the memory side
  typedef struct packed {
    logic [`ADDR_LEN-`BLOCK_OFF_BIT_LEN-1:0] block_addr;
    logic [`BLOCK_OFF_BIT_LEN-1:0]           block_offset;
  } addr_block_t;

  typedef union packed {
    addr_fields_t fields;
    addr_block_t  block;
  } cache_addr_u;

  // Single outstanding miss
  typedef struct packed {
    logic                 valid;
    logic                 rw_mode;      // 1 for store
    cache_addr_u          addr;
    logic [`WORD_LEN-1:0] store_value;
  } mshr_reg;

endpackage

//--- verilog/refill_execute.sv
`include "cache_macros.svh"
`timescale 1ns/1ps

module refill_execute import cache_types_pkg::*, mem_req_pkg::*; (
  input  logic                                CLK,
  input  logic                                reset,
  input  logic                                req_valid,
  input  logic                                req_rw,
  input  logic [`WORD_LEN-1:0]                req_store_value,
  input  cache_addr_u                         req_addr,
  input  logic                                hit,
  input  logic [`WAYS_LEN-1:0]                hit_way_index,
  input  logic [`BLOCK_INDEX_BIT_LEN-1:0]     set_index,
  input  logic [`BLOCK_OFF_BIT_LEN-1:0]       block_offset,
  input  lru_frame [`NUM_SETS_PER_BANK-1:0]   lru,
  output cache_set [`NUM_SETS_PER_BANK-1:0]   bank,
  output logic                                busy,
  output cache_addr_u                         replay_addr,
  output logic                                touch,
  output logic [`BLOCK_INDEX_BIT_LEN-1:0]     touch_set,
  output logic [`WAYS_LEN-1:0]                touch_way,
  output logic [`BLOCK_INDEX_BIT_LEN-1:0]     victim_set,
  output logic [`WAYS_LEN-1:0]                victim_way,
  output logic                                finish,
  output logic                                result_valid,
  output logic                                result_rw,
  output logic [`WORD_LEN-1:0]                result_word,
  output logic                                mem_read,
  output logic                                mem_write,
  output logic [`ADDR_LEN-1:0]                mem_addr,
  output logic [`WORD_LEN-1:0]                mem_wdata,
  input  logic                                mem_rvalid,
  input  logic [`WORD_LEN-1:0]                mem_rdata
);

  localparam logic [`BLOCK_OFF_BIT_LEN-1:0] LAST_WORD = `BLOCK_OFF_BIT_LEN'(`BLOCK_SIZE - 1);

  cache_state_e                          state;
  logic [`BLOCK_OFF_BIT_LEN-1:0]         count_fsm;
  logic                                  pull_wait;    // mem_read issued, no answer yet
  mshr_reg                               mshr;
  logic [`BLOCK_SIZE-1:0][`WORD_LEN-1:0] pull_block;

  logic [`NUM_SETS_PER_BANK-1:0][`NUM_WAYS-1:0]                    valid_q;
  logic [`NUM_SETS_PER_BANK-1:0][`NUM_WAYS-1:0][`TAG_LEN-1:0]      tag_q;
  logic [`NUM_SETS_PER_BANK-1:0][`NUM_WAYS-1:0][`BLOCK_SIZE-1:0][`WORD_LEN-1:0] data_q;

  logic                 serve;       // Hit or replay answered this cycle
  logic                 serve_rw;
  logic [`WORD_LEN-1:0] serve_data;
  logic                 miss_accept;
  cache_addr_u          eject_addr;
  cache_addr_u          pull_addr;

  always_comb begin
    for (int s = 0; s < `NUM_SETS_PER_BANK; s++) begin
      for (int w = 0; w < `NUM_WAYS; w++) begin
        bank[s][w].valid = valid_q[s][w];
        bank[s][w].tag   = tag_q[s][w];
        bank[s][w].block = data_q[s][w];
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Hit and replay service
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign miss_accept = (state == IDLE) && req_valid && !hit;
  assign serve       = ((state == IDLE) && req_valid && hit) || ((state == REPLAY) && mshr.valid);
  assign serve_rw    = (state == REPLAY) ? mshr.rw_mode : req_rw;
  assign serve_data  = (state == REPLAY) ? mshr.store_value : req_store_value;

  assign result_valid = serve;
  assign result_rw    = serve_rw;
  assign result_word  = data_q[set_index][hit_way_index][block_offset];

  assign touch     = serve || (state == FINISH);
  assign touch_set = (state == FINISH) ? victim_set : set_index;
  assign touch_way = (state == FINISH) ? victim_way : hit_way_index;
  assign finish    = (state == FINISH);

  assign busy        = (state != IDLE);
  assign replay_addr = mshr.addr;

  // Memory side addresses through the block view
  always_comb begin
    eject_addr.block.block_addr   = {tag_q[victim_set][victim_way], victim_set};
    eject_addr.block.block_offset = count_fsm;
    pull_addr.block.block_addr    = mshr.addr.block.block_addr;
    pull_addr.block.block_offset  = count_fsm;
  end

  assign mem_write = (state == VICTIM_EJECT);
  assign mem_read  = (state == BLOCK_PULL) && !pull_wait;
  assign mem_addr  = mem_write ? eject_addr : pull_addr;
  assign mem_wdata = data_q[victim_set][victim_way][count_fsm];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Miss FSM
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge CLK) begin
    if (reset) begin
      state      <= IDLE;
      count_fsm  <= '0;
      pull_wait  <= 1'b0;
      mshr.valid <= 1'b0;
      valid_q    <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (miss_accept) begin
            mshr      <= '{valid: 1'b1, rw_mode: req_rw, addr: req_addr,
                           store_value: req_store_value};
            count_fsm <= '0;
            pull_wait <= 1'b0;
            state     <= valid_q[set_index][lru[set_index].lru_way] ? VICTIM_EJECT : BLOCK_PULL;
          end
        end
        VICTIM_EJECT: begin
          count_fsm <= count_fsm + 1'b1;
          if (count_fsm == LAST_WORD) begin
            state <= BLOCK_PULL;
          end
        end
        BLOCK_PULL: begin
          if (mem_read) begin
            pull_wait <= 1'b1;
          end
          if (mem_rvalid) begin
            pull_wait <= 1'b0;
            count_fsm <= count_fsm + 1'b1;
            if (count_fsm == LAST_WORD) begin
              state <= FINISH;
            end
          end
        end
        FINISH: begin
          valid_q[victim_set][victim_way] <= 1'b1;
          state                           <= REPLAY;
        end
        REPLAY: begin
          mshr.valid <= 1'b0;
          state      <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Storage payload, victim choice and pull buffer
  always_ff @(posedge CLK) begin
    if (miss_accept) begin
      victim_set <= set_index;
      victim_way <= lru[set_index].lru_way;
    end
    if ((state == BLOCK_PULL) && mem_rvalid) begin
      pull_block[count_fsm] <= mem_rdata;
    end
    if (state == FINISH) begin
      tag_q[victim_set][victim_way]  <= mshr.addr.fields.tag;
      data_q[victim_set][victim_way] <= pull_block;
    end
    if (serve && serve_rw) begin
      data_q[set_index][hit_way_index][block_offset] <= serve_data;  // Store in one cycle
    end
  end

  // Last pulled word, then FINISH, then the frame holds the new block
  assert property (@(posedge CLK) disable iff (reset)
                   ((state == BLOCK_PULL) && mem_rvalid && (count_fsm == LAST_WORD)) |-> ##2
                   (bank[victim_set][victim_way].valid &&
                    (bank[victim_set][victim_way].tag == mshr.addr.fields.tag) &&
                    (bank[victim_set][victim_way].block === pull_block)))
    else $error("ASSERTIONERROR: block not replaced properly");

  assert property (@(posedge CLK) disable iff (reset)
                   (serve && serve_rw) |=>
                   (bank[$past(set_index)][$past(hit_way_index)].block[$past(block_offset)] ==
                    $past(serve_data)))
    else $error("ASSERTIONERROR: word not replaced properly within block");

endmodule

//--- verilog/response_result.sv
`include "cache_macros.svh"
`timescale 1ns/1ps

module response_result (
  input  logic                 CLK,
  input  logic                 reset,
  input  logic                 result_valid,
  input  logic                 result_rw,
  input  logic [`WORD_LEN-1:0] result_word,
  output logic                 resp_valid,
  output logic [`WORD_LEN-1:0] resp_load_value
);

  always_ff @(posedge CLK) begin
    if (reset) begin
      resp_valid <= 1'b0;
    end else begin
      resp_valid <= result_valid;     // One pulse per served request
    end
  end

  // Load data stays put across stores and idle cycles
  always_ff @(posedge CLK) begin
    if (result_valid && !result_rw) begin
      resp_load_value <= result_word;
    end
  end

  // Back-to-back pulses come only from back-to-back hits as a miss answers once
  assert property (@(posedge CLK) disable iff (reset)
                   (resp_valid && $past(resp_valid)) |-> ($past(result_valid, 2) &&
                                                          $past(result_valid)))
    else $error("ASSERTIONERROR: resp_valid held for two cycles during a miss");

endmodule
